/* compile.f */
rtl/aline_pkg.sv
rtl/sample_addressing.sv
rtl/adc_capture.sv
rtl/aline_buffer.sv
rtl/sine_nco.sv
rtl/axil_readout.sv
rtl/aline_acq_top.sv
tests/aline_acq_sva.sv
tests/aline_acq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the a-line acquisition testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module aline_acq_tb \
	-f compile.f -o aline_acq_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/aline_acq_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$log"; then
	exit 1
fi
exit 0

/* tests/aline_acq_tb.sv */
`timescale 1ns/100ps
module aline_acq_tb;
	import aline_pkg::*;

	typedef struct packed {
		logic [15:0]               len;    // trigger-high cycles
		logic [adc_width-1:0]      base;   // adc word at index 0
		logic [2:0][pos_width-1:0] idx;    // entries read back
	} line_row_t;

	localparam int n_rows         = 4;
	localparam int timeout_cycles = n_rows * (nsamples + 200) + 2000;

	// ====================
	// full, wrapping full, short, full
	localparam line_row_t rows [n_rows] = '{
		'{16'(nsamples + 20), 14'h0100, {11'd1169, 11'd1, 11'd0}},
		'{16'(nsamples + 5),  14'h3f00, {11'd1169, 11'd300, 11'd5}},
		'{16'd400,            14'h1234, {11'd399, 11'd17, 11'd0}},
		'{16'(nsamples + 50), 14'h2a00, {11'd1168, 11'd777, 11'd1}}
	};

	logic                 clk_system;
	logic                 global_reset_n;
	logic                 sweep_trigger;
	logic [adc_width-1:0] adc_data;
	logic [adc_width-1:0] dac_adc;
	logic [adc_width-1:0] dac_sine;
	logic                 acq_busy;
	axil_req_t            axil_req;
	axil_rsp_t            axil_rsp;
	int                   cycles = 0;

	aline_acq_top aline_acq_top_inst (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.sweep_trigger  (sweep_trigger),
		.adc_data       (adc_data),
		.dac_adc        (dac_adc),
		.dac_sine       (dac_sine),
		.acq_busy       (acq_busy),
		.axil_req       (axil_req),
		.axil_rsp       (axil_rsp)
	);

	initial begin
		clk_system = 1'b0;
		forever #4 clk_system = ~clk_system;   // 8 ns
	end

	// watchdog
	always @(posedge clk_system) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	// ====================
	// reporting and compares
	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [adc_width-1:0] got, want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] got, want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t got, want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, want);
		if (got !== want) begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, want);
			abort_run();
		end
	endtask

	// inputs change 1 ns past the edge
	task automatic wait_drive_slot();
		@(posedge clk_system);
		#1;
	endtask

	// ====================
	// axi4-lite master
	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
			output axi_resp_t resp);
		int stall;
		stall = $urandom_range(3, 0);   // bready back-pressure
		wait_drive_slot();
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hf;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		@(negedge clk_system);
		while (!axil_rsp.awready) @(negedge clk_system);
		check_flag("wready", axil_rsp.wready, 1'b1);   // accepted together with aw
		wait_drive_slot();
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		repeat (stall) wait_drive_slot();
		axil_req.bready = 1'b1;
		@(negedge clk_system);
		while (!axil_rsp.bvalid) @(negedge clk_system);
		resp = axil_rsp.bresp;
		wait_drive_slot();
		axil_req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
			output axi_resp_t resp);
		int stall;
		stall = $urandom_range(3, 0);   // rready back-pressure
		wait_drive_slot();
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		@(negedge clk_system);
		while (!axil_rsp.arready) @(negedge clk_system);
		wait_drive_slot();
		axil_req.arvalid = 1'b0;
		repeat (stall) wait_drive_slot();
		axil_req.rready = 1'b1;
		@(negedge clk_system);
		while (!axil_rsp.rvalid) @(negedge clk_system);   // latency varies
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		wait_drive_slot();
		axil_req.rready = 1'b0;
	endtask

	task automatic read_reg(input logic [15:0] addr, input string name, input logic [31:0] want);
		logic [31:0] rdata;
		axi_resp_t   resp;
		axi_read(addr, rdata, resp);
		check_resp("rresp", resp, resp_okay);
		check_reg(name, rdata, want);
	endtask

	// ====================
	// acquisition
	task automatic run_line(input line_row_t row);
		logic [adc_width-1:0] prev_adc;
		prev_adc = adc_data;
		for (int i = 0; i < row.len; i++) begin
			wait_drive_slot();
			check_word("dac_adc", dac_adc, prev_adc);   // mirror one edge behind
			if (i == 10) check_flag("acq_busy", acq_busy, 1'b1);
			sweep_trigger = 1'b1;
			adc_data      = row.base + adc_width'(i);
			prev_adc      = adc_data;
		end
		wait_drive_slot();
		sweep_trigger = 1'b0;
		repeat (3) wait_drive_slot();   // last write lands, counter clears
		check_flag("acq_busy", acq_busy, 1'b0);
	endtask

	task automatic check_line(input line_row_t row);
		logic [31:0]          rdata;
		axi_resp_t            resp;
		logic                 full;
		logic [adc_width-1:0] want;
		full = (row.len >= nsamples);
		axi_read(reg_status, rdata, resp);
		check_resp("rresp", resp, resp_okay);
		check_flag("line_done", rdata[1], full);
		if (full) begin
			axi_write(reg_status, 32'h2, resp);   // w1c
			check_resp("bresp", resp, resp_okay);
			read_reg(reg_status, "status", 32'h0);
		end
		for (int k = 0; k < 3; k++) begin
			want = (row.idx[k] == '0) ? '0 : row.base + adc_width'(row.idx[k]);
			axi_read(buf_base + 16'(4 * row.idx[k]), rdata, resp);
			check_resp("rresp", resp, resp_okay);
			check_word($sformatf("buf[%0d]", row.idx[k]), rdata[adc_width-1:0], want);
		end
	endtask

	// quarter-turn steps, four points per period
	task automatic check_sine();
		logic [adc_width-1:0] s [7];
		logic [adc_width-1:0] wave [4];
		axi_resp_t            resp;
		int                   k;
		wave = '{sine_mid, 14'h3fff, sine_mid, 14'h0001};
		axi_write(reg_phase_inc, 32'h4000_0000, resp);
		check_resp("bresp", resp, resp_okay);
		for (int i = 0; i < 7; i++) begin
			@(negedge clk_system);
			s[i] = dac_sine;
		end
		k = 0;
		while (k < 4 && s[k] != 14'h3fff) k++;
		if (k == 4) begin
			$display("dac_sine did not reach its positive peak within four cycles");
			abort_run();
		end
		for (int j = 0; j < 4; j++) begin
			check_word("dac_sine", s[k+j], wave[(j+1)%4]);
		end
	endtask

	task automatic check_errors();
		logic [31:0] rdata;
		axi_resp_t   resp;
		axi_write(reg_sine, 32'h1234, resp);   // read only
		check_resp("bresp", resp, resp_slverr);
		axi_write(buf_base + 16'h8, 32'h0055, resp);
		check_resp("bresp", resp, resp_slverr);
		axi_read(buf_base + 16'(4 * nsamples), rdata, resp);   // one past the line
		check_resp("rresp", resp, resp_slverr);
		check_reg("rdata", rdata, 32'h0);
		axi_read(buf_base + 16'h8, rdata, resp);   // entry 2 untouched
		check_resp("rresp", resp, resp_okay);
		check_word("buf[2]", rdata[adc_width-1:0], rows[n_rows-1].base + 14'd2);
		read_reg(reg_phase_inc, "phase_inc", 32'h4000_0000);
	endtask

	// ====================
	// main sequence
	initial begin
		void'($urandom(32'he712));
		global_reset_n = 1'b0;
		sweep_trigger  = 1'b0;
		adc_data       = '0;
		axil_req       = '0;
		repeat (5) @(posedge clk_system);
		#1 global_reset_n = 1'b1;

		check_flag("acq_busy", acq_busy, 1'b0);
		read_reg(reg_status, "status", 32'h0);
		read_reg(reg_phase_inc, "phase_inc", 32'h0);
		read_reg(reg_sine, "sine", {18'h0, sine_mid});

		for (int r = 0; r < n_rows; r++) begin
			run_line(rows[r]);
			check_line(rows[r]);
		end

		check_sine();
		check_errors();

		$display("TEST PASS");
		$finish;
	end

endmodule

/* tests/aline_acq_sva.sv */
`timescale 1ns/100ps
module aline_acq_sva (
	input logic                   clk_system,
	input logic                   global_reset_n,
	input logic                   sweep_trigger,
	input logic                   acq_busy,
	input aline_pkg::axil_req_t   axil_req,
	input aline_pkg::axil_rsp_t   axil_rsp,
	input aline_pkg::acq_status_t status,
	input aline_pkg::buf_wr_t     buf_wr
);
	import aline_pkg::*;

	// counter cleared by the reset edge
	busy_after_reset: assert property (@(posedge clk_system)
		!global_reset_n |=> !acq_busy)
		else $error("acq_busy high in the cycle after reset");

	// ====================
	// response channels hold under back-pressure
	rvalid_hold: assert property (@(posedge clk_system) disable iff (!global_reset_n)
		axil_rsp.rvalid && !axil_req.rready |=>
			axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
		else $error("read response dropped or changed before rready");

	bvalid_hold: assert property (@(posedge clk_system) disable iff (!global_reset_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else $error("write response dropped or changed before bready");

	done_at_last: assert property (@(posedge clk_system) disable iff (!global_reset_n)
		$rose(status.line_done) |-> status.position == pos_width'(nsamples - 1))
		else $error("line_done rose away from the last position");

	// write lags capture by one edge
	write_in_sweep: assert property (@(posedge clk_system) disable iff (!global_reset_n)
		buf_wr.en |-> $past(sweep_trigger))
		else $error("buffer write without a trigger-high capture cycle");

endmodule

bind aline_acq_top aline_acq_sva aline_acq_sva_inst (
	.clk_system     (clk_system),
	.global_reset_n (global_reset_n),
	.sweep_trigger  (sweep_trigger),
	.acq_busy       (acq_busy),
	.axil_req       (axil_req),
	.axil_rsp       (axil_rsp),
	.status         (status),
	.buf_wr         (buf_wr)
);

/* rtl/aline_acq_top.sv */
`timescale 1ns/100ps
module aline_acq_top (
	input  logic                              clk_system,
	input  logic                              global_reset_n,
	input  logic                              sweep_trigger,
	input  logic [aline_pkg::adc_width-1:0]   adc_data,
	output logic [aline_pkg::adc_width-1:0]   dac_adc,
	output logic [aline_pkg::adc_width-1:0]   dac_sine,
	output logic                              acq_busy,
	input  aline_pkg::axil_req_t              axil_req,
	output aline_pkg::axil_rsp_t              axil_rsp
);
	import aline_pkg::*;

	acq_status_t            status;
	buf_wr_t                buf_wr;
	logic                   clear_done;
	logic [phase_width-1:0] phase_inc;
	logic [pos_width-1:0]   buf_addr;
	logic [adc_width-1:0]   buf_data;

	assign acq_busy = status.busy;

	// ====================
	// acquisition path
	sample_addressing sample_addressing_inst (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.sweep_trigger  (sweep_trigger),
		.clear_done     (clear_done),      // from status w1c
		.status         (status)
	);

	adc_capture adc_capture_inst (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.sweep_trigger  (sweep_trigger),
		.adc_data       (adc_data),        // already on clk_system
		.status         (status),
		.wr             (buf_wr),
		.dac_adc        (dac_adc)
	);

	aline_buffer aline_buffer_inst (
		.clk_system     (clk_system),
		.wr             (buf_wr),
		.rd_addr        (buf_addr),
		.rd_data        (buf_data)
	);

	// dac a sine
	sine_nco sine_nco_inst (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.phase_inc      (phase_inc),
		.sine           (dac_sine)
	);

	// ====================
	// software access
	axil_readout axil_readout_inst (
		.clk_system     (clk_system),
		.global_reset_n (global_reset_n),
		.axil_req       (axil_req),
		.axil_rsp       (axil_rsp),
		.status         (status),
		.sine           (dac_sine),
		.phase_inc      (phase_inc),
		.clear_done     (clear_done),
		.buf_addr       (buf_addr),
		.buf_data       (buf_data)
	);

endmodule

/* rtl/axil_readout.sv */
`timescale 1ns/100ps
module axil_readout (
	input  logic                                clk_system,
	input  logic                                global_reset_n,
	input  aline_pkg::axil_req_t                axil_req,
	output aline_pkg::axil_rsp_t                axil_rsp,
	input  aline_pkg::acq_status_t              status,
	input  logic [aline_pkg::adc_width-1:0]     sine,
	output logic [aline_pkg::phase_width-1:0]   phase_inc,
	output logic                                clear_done,
	output logic [aline_pkg::pos_width-1:0]     buf_addr,
	input  logic [aline_pkg::adc_width-1:0]     buf_data
);
	import aline_pkg::*;

	typedef enum logic {wr_idle, wr_resp} wr_state_t;
	typedef enum logic [1:0] {rd_idle, rd_wait_ram, rd_resp} rd_state_t;

	wr_state_t   wr_state;
	rd_state_t   rd_state;
	axi_resp_t   bresp;
	axi_resp_t   rresp;
	logic [31:0] rdata;
	logic        wr_fire;
	logic        rd_fire;
	logic [15:0] rd_off;      // offset into buffer window
	logic        rd_buf_hit;
	logic        reg_hit;
	logic [31:0] reg_rdata;

	// both aw and w needed, one write in flight
	assign wr_fire = (wr_state == wr_idle) && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = (rd_state == rd_idle) && axil_req.arvalid;

	assign rd_off     = axil_req.araddr - buf_base;
	assign rd_buf_hit = (axil_req.araddr >= buf_base) && (rd_off[15:2] < nsamples);
	assign buf_addr   = rd_off[pos_width+1:2];   // ram sees it on the accept edge

	assign clear_done = wr_fire && (axil_req.awaddr == reg_status)
	                    && axil_req.wstrb[0] && axil_req.wdata[1];

	// ====================
	// register read decode
	always_comb begin
		reg_hit   = 1'b1;
		reg_rdata = '0;
		case (axil_req.araddr)
			reg_status: begin
				reg_rdata[0]               = status.busy;
				reg_rdata[1]               = status.line_done;
				reg_rdata[16 +: pos_width] = status.position;
			end
			reg_phase_inc: reg_rdata = phase_inc;
			reg_sine:      reg_rdata[adc_width-1:0] = sine;
			default:       reg_hit = 1'b0;   // rdata stays 0
		endcase
	end

	// ====================
	// write channel
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			wr_state  <= wr_idle;
			bresp     <= resp_okay;
			phase_inc <= '0;
		end else begin
			case (wr_state)
				wr_idle: if (wr_fire) begin
					wr_state <= wr_resp;
					case (axil_req.awaddr)
						reg_status: bresp <= resp_okay;   // only the w1c bit acts
						reg_phase_inc: begin
							bresp <= resp_okay;
							for (int b = 0; b < 4; b++) begin
								if (axil_req.wstrb[b]) begin
									phase_inc[8*b +: 8] <= axil_req.wdata[8*b +: 8];
								end
							end
						end
						default: bresp <= resp_slverr;   // sine, buffer, unmapped
					endcase
				end
				wr_resp: if (axil_req.bready) begin
					wr_state <= wr_idle;
				end
				default: wr_state <= wr_idle;
			endcase
		end
	end

	// ====================
	// read channel, buffer takes an extra edge
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: if (rd_fire) begin
					rd_state <= rd_buf_hit ? rd_wait_ram : rd_resp;
				end
				rd_wait_ram: rd_state <= rd_resp;
				rd_resp: if (axil_req.rready) begin
					rd_state <= rd_idle;
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge clk_system) begin
		if (rd_fire) begin
			rdata <= reg_rdata;
			rresp <= (reg_hit || rd_buf_hit) ? resp_okay : resp_slverr;
		end else if (rd_state == rd_wait_ram) begin
			rdata <= {{(32-adc_width){1'b0}}, buf_data};   // ram output now valid
		end
	end

	assign axil_rsp.awready = wr_fire;
	assign axil_rsp.wready  = wr_fire;
	assign axil_rsp.bresp   = bresp;
	assign axil_rsp.bvalid  = (wr_state == wr_resp);
	assign axil_rsp.arready = rd_fire;
	assign axil_rsp.rdata   = rdata;
	assign axil_rsp.rresp   = rresp;
	assign axil_rsp.rvalid  = (rd_state == rd_resp);

endmodule

/* rtl/sine_nco.sv */
`timescale 1ns/100ps
module sine_nco (
	input  logic                                clk_system,
	input  logic                                global_reset_n,
	input  logic [aline_pkg::phase_width-1:0]   phase_inc,
	output logic [aline_pkg::adc_width-1:0]     sine
);
	import aline_pkg::*;

	// quarter wave, entries 0 .. 2**lut_bits inclusive
	function automatic logic [((2**lut_bits)+1)*adc_width-1:0] build_lut();
		logic [((2**lut_bits)+1)*adc_width-1:0] t;
		real step;
		real s;
		step = 1.5707963267948966 / real'(2**lut_bits);   // pi/2 per quarter
		t = '0;                                            // entry 0 exact zero
		for (int i = 1; i < 2**lut_bits; i++) begin
			s = $sin(i * step) * sine_amp;
			t[i*adc_width +: adc_width] = adc_width'($rtoi(s + 0.5));
		end
		t[(2**lut_bits)*adc_width +: adc_width] = adc_width'(sine_amp);  // peak exact
		return t;
	endfunction

	logic [((2**lut_bits)+1)*adc_width-1:0] sine_lut;
	logic [phase_width-1:0] phase;
	logic [1:0]             quadrant;
	logic [lut_bits-1:0]    idx;
	logic [lut_bits:0]      lut_addr;    // one extra bit for the peak entry
	logic [adc_width-1:0]   mag;

	assign sine_lut = build_lut();

	// ====================
	// phase to magnitude
	assign quadrant = phase[phase_width-1 -: 2];
	assign idx      = phase[phase_width-3 -: lut_bits];
	assign lut_addr = quadrant[0] ? ((lut_bits+1)'(2**lut_bits) - {1'b0, idx})  // mirrored
	                              : {1'b0, idx};
	assign mag      = sine_lut[lut_addr*adc_width +: adc_width];

	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			phase <= '0;
		end else begin
			phase <= phase + phase_inc;
		end
	end

	// offset binary, negative half below midscale
	// same result as flipping the msb of a two's complement sine
	always_ff @(posedge clk_system) begin
		sine <= quadrant[1] ? (sine_mid - mag) : (sine_mid + mag);
	end

endmodule

/* rtl/aline_buffer.sv */
`timescale 1ns/100ps
module aline_buffer (
	input  logic                              clk_system,
	input  aline_pkg::buf_wr_t                wr,
	input  logic [aline_pkg::pos_width-1:0]   rd_addr,
	output logic [aline_pkg::adc_width-1:0]   rd_data
);
	import aline_pkg::*;

	// ====================
	// one a-line, block ram
	logic [adc_width-1:0] mem [nsamples];

	// write port, capture side
	always_ff @(posedge clk_system) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// registered read, axi side
	// addresses past the line are filtered by the slave
	always_ff @(posedge clk_system) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* rtl/adc_capture.sv */
`timescale 1ns/100ps
module adc_capture (
	input  logic                              clk_system,
	input  logic                              global_reset_n,
	input  logic                              sweep_trigger,
	input  logic [aline_pkg::adc_width-1:0]   adc_data,
	input  aline_pkg::acq_status_t            status,
	output aline_pkg::buf_wr_t                wr,
	output logic [aline_pkg::adc_width-1:0]   dac_adc
);
	import aline_pkg::*;

	logic [adc_width-1:0] adc_q;     // registered adc word
	logic [pos_width-1:0] pos_q;     // position sampled with it
	logic                 wr_pend;
	logic                 at_end;    // last cycle already sat at final position
	logic                 at_hold;

	// repeated final position, nothing new to store
	assign at_hold = (status.position == pos_width'(nsamples - 1)) && at_end;

	always_ff @(posedge clk_system) begin
		adc_q <= adc_data;
		pos_q <= status.position;
	end

	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			wr_pend <= 1'b0;
			at_end  <= 1'b0;
		end else begin
			wr_pend <= sweep_trigger && !at_hold;
			at_end  <= sweep_trigger && (status.position == pos_width'(nsamples - 1));
		end
	end

	// write one edge after capture
	assign wr.en   = wr_pend;
	assign wr.addr = pos_q;
	assign wr.data = (pos_q == '0) ? '0 : adc_q;   // zero marks line start
	assign dac_adc = adc_q;                         // mirror to dac b

endmodule

/* rtl/sample_addressing.sv */
`timescale 1ns/100ps
module sample_addressing (
	input  logic                   clk_system,
	input  logic                   global_reset_n,
	input  logic                   sweep_trigger,   // high during laser sweep
	input  logic                   clear_done,      // w1c pulse from axi
	output aline_pkg::acq_status_t status
);
	import aline_pkg::*;

	logic [pos_width-1:0] position;
	logic                 line_done;
	logic                 at_last;
	logic                 to_last;
	logic                 line_start;

	assign at_last    = (position == pos_width'(nsamples - 1));
	assign to_last    = sweep_trigger && (position == pos_width'(nsamples - 2));
	assign line_start = sweep_trigger && (position == '0);  // first trigger-high cycle

	// saturating counter, cleared while trigger low
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			position <= '0;
		end else if (!sweep_trigger) begin
			position <= '0;
		end else if (!at_last) begin
			position <= position + 1'b1;
		end
	end

	// sticky done flag
	always_ff @(posedge clk_system) begin
		if (!global_reset_n) begin
			line_done <= 1'b0;
		end else if (to_last) begin
			line_done <= 1'b1;   // set wins over a same-cycle clear
		end else if (clear_done || line_start) begin
			line_done <= 1'b0;
		end
	end

	assign status.position  = position;
	assign status.busy      = (position != '0) && !at_last;
	assign status.line_done = line_done;

endmodule

/* rtl/aline_pkg.sv */
package aline_pkg;

	// ====================
	// widths and sizes
	localparam int adc_width   = 14;      // adc and dac word
	localparam int nsamples    = 1170;    // samples per a-line
	localparam int pos_width   = 11;      // sample position
	localparam int phase_width = 32;      // nco accumulator
	localparam int lut_bits    = 8;       // quarter-wave table address
	localparam int sine_amp    = 8191;    // peak magnitude
	localparam logic [adc_width-1:0] sine_mid = 14'h2000;  // offset binary zero

	// ====================
	// register map, byte addresses
	localparam logic [15:0] reg_status    = 16'h0000;  // busy, line_done, position
	localparam logic [15:0] reg_phase_inc = 16'h0004;
	localparam logic [15:0] reg_sine      = 16'h0008;  // read only
	localparam logic [15:0] buf_base      = 16'h1000;  // line buffer window

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_t;

	// ====================
	// bus structs
	typedef struct packed {
		logic [15:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [15:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		axi_resp_t   bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		axi_resp_t   rresp;
		logic        rvalid;
	} axil_rsp_t;

	typedef struct packed {
		logic                 en;
		logic [pos_width-1:0] addr;
		logic [adc_width-1:0] data;
	} buf_wr_t;

	typedef struct packed {
		logic                 busy;
		logic                 line_done;   // sticky until w1c
		logic [pos_width-1:0] position;
	} acq_status_t;

endpackage
